// ==== servo_sig_pkg.sv ====
// sample words are two's complement and the internal signal keeps 8 extra low bits below the ADC
package servo_sig_pkg;

	////////////////////////////////////////////////////////////////////////////
	// converter and datapath widths

	// raw ADC sample width
	localparam int ADC_W = 16;

	// internal signal width through the filters
	localparam int SIG_W = 24;

	// word width sent to each DAC
	localparam int DAC_W = 16;

	// two servo channels
	localparam int N_CH = 2;

	////////////////////////////////////////////////////////////////////////////
	// word types

	typedef logic signed [ADC_W-1:0] adc_word_t;

	typedef logic signed [SIG_W-1:0] sig_t;

	typedef logic signed [DAC_W-1:0] dac_word_t;

endpackage

// ==== servo_cfg_pkg.sv ====
// coefficients are signed fixed point with 16 fraction bits, so gains stay within about +/-2
package servo_cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// coefficient format

	// total coefficient width incl sign
	localparam int COEF_W = 18;

	// fraction bits with 1.0 at 2**16
	localparam int COEF_FRAC = 16;

	typedef logic signed [COEF_W-1:0] coef_t;

	////////////////////////////////////////////////////////////////////////////
	// command port opcodes

	// each opcode writes one field of the addressed channel
	typedef enum logic [1:0] {
		// filter on flag from data bit 0
		op_set_on = 2'd0,
		// feedback coefficient
		op_set_a1 = 2'd1,
		// feed-forward coefficient on x
		op_set_b0 = 2'd2,
		// feed-forward coefficient on x_prev
		op_set_b1 = 2'd3
	} cfg_op_e;

endpackage

// ==== adc_capture.sv ====
// samples load only on i_adc_valid and hold otherwise; there is no back-pressure on the strobe
module adc_capture (
	input  logic                     clk1,
	input  logic                     i_rst,
	input  logic                     i_adc_valid,
	input  servo_sig_pkg::adc_word_t i_adc0,
	input  servo_sig_pkg::adc_word_t i_adc1,
	output logic                     o_valid,
	output servo_sig_pkg::sig_t      o_sample0,
	output servo_sig_pkg::sig_t      o_sample1
);

	// zero bits appended below the ADC word
	localparam int PAD_W = servo_sig_pkg::SIG_W - servo_sig_pkg::ADC_W;

	servo_sig_pkg::adc_word_t adc0_q;
	servo_sig_pkg::adc_word_t adc1_q;
	logic valid_q;

	// strobe register
	always_ff @(posedge clk1) begin
		if (i_rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_adc_valid;
		end
	end

	// sample registers load both channels on the same strobe
	always_ff @(posedge clk1) begin
		if (i_adc_valid) begin
			adc0_q <= i_adc0;
			adc1_q <= i_adc1;
		end
	end

	assign o_valid = valid_q;

	// ADC word sits in the top bits of the wider signal
	assign o_sample0 = {adc0_q, {PAD_W{1'b0}}};
	assign o_sample1 = {adc1_q, {PAD_W{1'b0}}};

	// a floating strobe would corrupt the whole sample pipeline downstream
	a_adc_valid_known: assert property (@(posedge clk1) disable iff (i_rst)
		!$isunknown(i_adc_valid))
	else
		$error("adc_capture: i_adc_valid unknown");

endmodule

// ==== filter_cfg_regs.sv ====
// one field per write; new values reach the filters on the cycle after the write
module filter_cfg_regs (
	input  logic                    clk1,
	input  logic                    i_rst,
	input  logic                    i_cfg_we,
	input  servo_cfg_pkg::cfg_op_e  i_cfg_op,
	input  logic                    i_cfg_ch,
	input  servo_cfg_pkg::coef_t    i_cfg_data,
	output logic                    o_on0,
	output logic                    o_on1,
	output servo_cfg_pkg::coef_t    o_a1_0,
	output servo_cfg_pkg::coef_t    o_b0_0,
	output servo_cfg_pkg::coef_t    o_b1_0,
	output servo_cfg_pkg::coef_t    o_a1_1,
	output servo_cfg_pkg::coef_t    o_b0_1,
	output servo_cfg_pkg::coef_t    o_b1_1
);

	////////////////////////////////////////////////////////////////////////////
	// per-channel settings

	logic [servo_sig_pkg::N_CH-1:0] on_q;
	servo_cfg_pkg::coef_t a1_q [servo_sig_pkg::N_CH];
	servo_cfg_pkg::coef_t b0_q [servo_sig_pkg::N_CH];
	servo_cfg_pkg::coef_t b1_q [servo_sig_pkg::N_CH];

	// command decode
	always_ff @(posedge clk1) begin
		if (i_rst) begin
			// all filters off and all gains zero
			on_q <= '0;
			for (int ch = 0; ch < servo_sig_pkg::N_CH; ch++) begin
				a1_q[ch] <= '0;
				b0_q[ch] <= '0;
				b1_q[ch] <= '0;
			end
		end else if (i_cfg_we) begin
			case (i_cfg_op)
				servo_cfg_pkg::op_set_on: on_q[i_cfg_ch] <= i_cfg_data[0];
				servo_cfg_pkg::op_set_a1: a1_q[i_cfg_ch] <= i_cfg_data;
				servo_cfg_pkg::op_set_b0: b0_q[i_cfg_ch] <= i_cfg_data;
				servo_cfg_pkg::op_set_b1: b1_q[i_cfg_ch] <= i_cfg_data;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// level outputs to the filters

	assign o_on0  = on_q[0];
	assign o_on1  = on_q[1];
	assign o_a1_0 = a1_q[0];
	assign o_b0_0 = b0_q[0];
	assign o_b1_0 = b1_q[0];
	assign o_a1_1 = a1_q[1];
	assign o_b0_1 = b0_q[1];
	assign o_b1_1 = b1_q[1];

	// a bad opcode or channel would silently retune the wrong filter
	// every 2-bit code is an opcode, so only unknown bits are illegal
	a_cfg_op_legal: assert property (@(posedge clk1) disable iff (i_rst)
		i_cfg_we |-> !$isunknown({i_cfg_ch, i_cfg_op}))
	else
		$error("filter_cfg_regs: unknown command op or channel");

endmodule

// ==== iir_first_order.sv ====
// SIG_OUT_W must lie between ADC_W and SIG_W; both filter and bypass paths saturate to it
module iir_first_order #(
	parameter int SIG_OUT_W = 24
) (
	input  logic                 clk1,
	input  logic                 i_rst,
	input  logic                 i_valid,
	input  servo_sig_pkg::sig_t  i_sample,
	input  logic                 i_on,
	input  servo_cfg_pkg::coef_t i_a1,
	input  servo_cfg_pkg::coef_t i_b0,
	input  servo_cfg_pkg::coef_t i_b1,
	output logic                 o_valid,
	output servo_sig_pkg::sig_t  o_sample
);

	////////////////////////////////////////////////////////////////////////////
	// widths and limits

	// product plus two bits of growth for the three-term sum
	localparam int ACC_W = servo_cfg_pkg::COEF_W + servo_sig_pkg::SIG_W + 2;

	// signed limits of the output range at accumulator width
	localparam logic signed [ACC_W-1:0] SAT_MAX =
		{{(ACC_W-SIG_OUT_W+1){1'b0}}, {(SIG_OUT_W-1){1'b1}}};
	localparam logic signed [ACC_W-1:0] SAT_MIN = ~SAT_MAX;

	if (SIG_OUT_W < servo_sig_pkg::ADC_W || SIG_OUT_W > servo_sig_pkg::SIG_W) begin : g_bad_w
		$error("iir_first_order: SIG_OUT_W %0d out of range", SIG_OUT_W);
	end

	// clamp a wide value into the output range
	function automatic logic signed [SIG_OUT_W-1:0] sat_out(
		input logic signed [ACC_W-1:0] v
	);
		if (v > SAT_MAX) begin
			return SAT_MAX[SIG_OUT_W-1:0];
		end
		if (v < SAT_MIN) begin
			return SAT_MIN[SIG_OUT_W-1:0];
		end
		return v[SIG_OUT_W-1:0];
	endfunction

	// filter state
	servo_sig_pkg::sig_t x_q;
	logic signed [SIG_OUT_W-1:0] y_q;
	logic valid_q;

	// datapath
	logic signed [ACC_W-1:0] p_b0;
	logic signed [ACC_W-1:0] p_b1;
	logic signed [ACC_W-1:0] p_a1;
	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] acc_sh;
	logic signed [ACC_W-1:0] x_ext;
	logic signed [SIG_OUT_W-1:0] y_next;

	////////////////////////////////////////////////////////////////////////////
	// y = (b0*x + b1*x_prev + a1*y_prev) >>> COEF_FRAC

	assign p_b0   = i_b0 * i_sample;
	assign p_b1   = i_b1 * x_q;
	assign p_a1   = i_a1 * y_q;
	assign acc    = p_b0 + p_b1 + p_a1;
	assign acc_sh = acc >>> servo_cfg_pkg::COEF_FRAC;

	// bypass path sign extended so the same clamp applies
	assign x_ext = i_sample;

	// when off pass x while y_prev still follows the output
	assign y_next = i_on ? sat_out(acc_sh) : sat_out(x_ext);

	always_ff @(posedge clk1) begin
		if (i_rst) begin
			x_q     <= '0;
			y_q     <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_valid;
			if (i_valid) begin
				x_q <= i_sample;
				y_q <= y_next;
			end
		end
	end

	assign o_valid  = valid_q;
	assign o_sample = servo_sig_pkg::sig_t'(y_q);

	// one result per sample one cycle later and never unknown
	a_iir_latency: assert property (@(posedge clk1) disable iff (i_rst)
		(i_valid |=> o_valid && !$isunknown(o_sample)) and (!i_valid |=> !o_valid))
	else
		$error("iir_first_order: result strobe out of step with input");

endmodule

// ==== dac_output.sv ====
// the difference wraps at SIG_W; DAC words hold between strobes and read zero after reset
module dac_output #(
	parameter int DAC_W_P = 16
) (
	input  logic                      clk1,
	input  logic                      i_rst,
	input  logic                      i_valid,
	input  servo_sig_pkg::sig_t       i_filt0,
	input  servo_sig_pkg::sig_t       i_filt1,
	output servo_sig_pkg::dac_word_t  o_dac0,
	output servo_sig_pkg::dac_word_t  o_dac1,
	output logic                      o_dac_strobe
);

	// msb of the internal signal
	localparam int MSB = servo_sig_pkg::SIG_W - 1;

	if (DAC_W_P > servo_sig_pkg::SIG_W) begin : g_bad_w
		$error("dac_output: DAC_W_P %0d wider than signal", DAC_W_P);
	end

	servo_sig_pkg::sig_t diff;
	logic signed [DAC_W_P-1:0] dac0_q;
	logic signed [DAC_W_P-1:0] dac1_q;
	logic strobe_q;

	// error signal for the second DAC wraps modulo 2**SIG_W
	assign diff = i_filt0 - i_filt1;

	always_ff @(posedge clk1) begin
		if (i_rst) begin
			dac0_q   <= '0;
			dac1_q   <= '0;
			strobe_q <= 1'b0;
		end else begin
			strobe_q <= i_valid;
			// keep the top bits only
			if (i_valid) begin
				dac0_q <= i_filt0[MSB -: DAC_W_P];
				dac1_q <= diff[MSB -: DAC_W_P];
			end
		end
	end

	assign o_dac0       = servo_sig_pkg::dac_word_t'(dac0_q);
	assign o_dac1       = servo_sig_pkg::dac_word_t'(dac1_q);
	assign o_dac_strobe = strobe_q;

	// back-to-back DAC strobes only from back-to-back filter results
	a_strobe_pairs: assert property (@(posedge clk1) disable iff (i_rst)
		(o_dac_strobe && $past(o_dac_strobe)) |-> ($past(i_valid) && $past(i_valid, 2)))
	else
		$error("dac_output: double strobe without double input");

endmodule

// ==== servo_top.sv ====
// fixed 3-cycle latency from i_adc_valid to o_dac_strobe; strobes may come every cycle
module servo_top (
	input  logic                      clk1,
	input  logic                      i_rst,
	input  logic                      i_adc_valid,
	input  servo_sig_pkg::adc_word_t  i_adc0,
	input  servo_sig_pkg::adc_word_t  i_adc1,
	input  logic                      i_cfg_we,
	input  servo_cfg_pkg::cfg_op_e    i_cfg_op,
	input  logic                      i_cfg_ch,
	input  servo_cfg_pkg::coef_t      i_cfg_data,
	output servo_sig_pkg::dac_word_t  o_dac0,
	output servo_sig_pkg::dac_word_t  o_dac1,
	output logic                      o_dac_strobe
);

	// capture to filters
	logic cap_valid;
	servo_sig_pkg::sig_t cap_sample0;
	servo_sig_pkg::sig_t cap_sample1;

	// settings as held levels
	logic on0;
	logic on1;
	servo_cfg_pkg::coef_t a1_0;
	servo_cfg_pkg::coef_t b0_0;
	servo_cfg_pkg::coef_t b1_0;
	servo_cfg_pkg::coef_t a1_1;
	servo_cfg_pkg::coef_t b0_1;
	servo_cfg_pkg::coef_t b1_1;

	// filters to DAC side
	logic filt_valid;
	servo_sig_pkg::sig_t filt0;
	servo_sig_pkg::sig_t filt1;

	////////////////////////////////////////////////////////////////////////////
	// input side and settings

	adc_capture u_capture (
		.clk1(clk1), .i_rst(i_rst), .i_adc_valid(i_adc_valid),
		.i_adc0(i_adc0), .i_adc1(i_adc1),
		.o_valid(cap_valid), .o_sample0(cap_sample0), .o_sample1(cap_sample1)
	);

	filter_cfg_regs u_cfg (
		.clk1(clk1), .i_rst(i_rst), .i_cfg_we(i_cfg_we), .i_cfg_op(i_cfg_op),
		.i_cfg_ch(i_cfg_ch), .i_cfg_data(i_cfg_data),
		.o_on0(on0), .o_on1(on1),
		.o_a1_0(a1_0), .o_b0_0(b0_0), .o_b1_0(b1_0),
		.o_a1_1(a1_1), .o_b0_1(b0_1), .o_b1_1(b1_1)
	);

	////////////////////////////////////////////////////////////////////////////
	// one filter per channel

	iir_first_order #(.SIG_OUT_W(servo_sig_pkg::SIG_W)) u_iir0 (
		.clk1(clk1), .i_rst(i_rst), .i_valid(cap_valid), .i_sample(cap_sample0),
		.i_on(on0), .i_a1(a1_0), .i_b0(b0_0), .i_b1(b1_0),
		.o_valid(filt_valid), .o_sample(filt0)
	);

	// strobe matches u_iir0 so it stays open
	iir_first_order #(.SIG_OUT_W(servo_sig_pkg::SIG_W)) u_iir1 (
		.clk1(clk1), .i_rst(i_rst), .i_valid(cap_valid), .i_sample(cap_sample1),
		.i_on(on1), .i_a1(a1_1), .i_b0(b0_1), .i_b1(b1_1),
		.o_valid(), .o_sample(filt1)
	);

	// output side
	dac_output #(.DAC_W_P(servo_sig_pkg::DAC_W)) u_dac (
		.clk1(clk1), .i_rst(i_rst), .i_valid(filt_valid),
		.i_filt0(filt0), .i_filt1(filt1),
		.o_dac0(o_dac0), .o_dac1(o_dac1), .o_dac_strobe(o_dac_strobe)
	);

endmodule

// ==== tb_servo.sv ====
// config writes take effect in the model at once since the filters read settings one cycle late
module tb_servo;
	timeunit 1ns;
	timeprecision 100ps;

	// sample counts per test section
	localparam int N_BYP  = 30;
	localparam int N_B2B  = 20;
	localparam int N_STEP = 10;
	localparam int N_FILT = 20;
	localparam int N_SAT  = 8;
	localparam int N_ISO  = 10;
	// worst case doubles the gapped sections and adds reset, idles, writes and margin
	localparam int LIMIT = 5 + 2 * (N_BYP + N_FILT + 3 * N_ISO) + N_B2B + N_STEP
		+ 2 * N_SAT + 16 + 6 * 8 + 50;

	logic clk1;
	logic i_rst;
	logic i_adc_valid;
	servo_sig_pkg::adc_word_t i_adc0;
	servo_sig_pkg::adc_word_t i_adc1;
	logic i_cfg_we;
	servo_cfg_pkg::cfg_op_e i_cfg_op;
	logic i_cfg_ch;
	servo_cfg_pkg::coef_t i_cfg_data;
	servo_sig_pkg::dac_word_t o_dac0;
	servo_sig_pkg::dac_word_t o_dac1;
	logic o_dac_strobe;

	int seed = 32'h978d;
	int val_errs = 0;
	int time_errs = 0;
	int other_errs = 0;
	int cycles = 0;
	logic sample_seen = 1'b0;
	logic sat_pos_hit = 1'b0;
	logic sat_neg_hit = 1'b0;
	// expected {dac0, dac1} in strobe order
	logic [31:0] exp_q [$];

	// reference model state per channel
	logic on_m [2];
	longint a1_m [2];
	longint b0_m [2];
	longint b1_m [2];
	longint xp [2];
	longint yp [2];

	servo_top u_dut (
		.clk1(clk1), .i_rst(i_rst), .i_adc_valid(i_adc_valid),
		.i_adc0(i_adc0), .i_adc1(i_adc1),
		.i_cfg_we(i_cfg_we), .i_cfg_op(i_cfg_op), .i_cfg_ch(i_cfg_ch), .i_cfg_data(i_cfg_data),
		.o_dac0(o_dac0), .o_dac1(o_dac1), .o_dac_strobe(o_dac_strobe)
	);

	initial begin
		clk1 = 1'b0;
		forever #2 clk1 = ~clk1;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model

	// one strobe through both filters pushes the expected DAC pair
	task automatic model_step(input servo_sig_pkg::adc_word_t a0,
		input servo_sig_pkg::adc_word_t a1v);
		longint x;
		longint y [2];
		logic [63:0] d0;
		logic [63:0] d1;
		for (int ch = 0; ch < 2; ch++) begin
			// widened sample is the adc word times 2**8
			x = (ch == 0) ? longint'(a0) * 256 : longint'(a1v) * 256;
			if (on_m[ch]) begin
				y[ch] = (b0_m[ch] * x + b1_m[ch] * xp[ch] + a1_m[ch] * yp[ch]) >>> 16;
				if (y[ch] > 64'sd8388607) begin
					y[ch] = 64'sd8388607;
					sat_pos_hit = sat_pos_hit | (ch == 0);
				end else if (y[ch] < -64'sd8388608) begin
					y[ch] = -64'sd8388608;
					sat_neg_hit = sat_neg_hit | (ch == 0);
				end
			end else begin
				y[ch] = x;
			end
			xp[ch] = x;
			yp[ch] = y[ch];
		end
		d0 = y[0];
		// difference wraps at 24 bits and only bits 23..8 matter
		d1 = y[0] - y[1];
		exp_q.push_back({d0[23:8], d1[23:8]});
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus tasks drive on the falling edge

	task automatic send_sample(input servo_sig_pkg::adc_word_t a0,
		input servo_sig_pkg::adc_word_t a1v);
		@(negedge clk1);
		i_cfg_we = 1'b0;
		i_adc_valid = 1'b1;
		i_adc0 = a0;
		i_adc1 = a1v;
		sample_seen = 1'b1;
		model_step(a0, a1v);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk1);
			i_adc_valid = 1'b0;
			i_cfg_we = 1'b0;
		end
	endtask

	task automatic write_cfg(input servo_cfg_pkg::cfg_op_e op, input logic ch,
		input servo_cfg_pkg::coef_t data);
		@(negedge clk1);
		i_adc_valid = 1'b0;
		i_cfg_we = 1'b1;
		i_cfg_op = op;
		i_cfg_ch = ch;
		i_cfg_data = data;
		case (op)
			servo_cfg_pkg::op_set_on: on_m[ch] = data[0];
			servo_cfg_pkg::op_set_a1: a1_m[ch] = longint'(data);
			servo_cfg_pkg::op_set_b0: b0_m[ch] = longint'(data);
			default: b1_m[ch] = longint'(data);
		endcase
	endtask

	// random samples with optional random idle gaps
	task automatic send_random(input int n, input logic gaps);
		for (int i = 0; i < n; i++) begin
			send_sample(servo_sig_pkg::adc_word_t'($random(seed)),
				servo_sig_pkg::adc_word_t'($random(seed)));
			if (gaps && $random(seed) % 2 == 0) begin
				idle(1);
			end
		end
	endtask

	task automatic send_const(input int n, input servo_sig_pkg::adc_word_t a0,
		input servo_sig_pkg::adc_word_t a1v);
		repeat (n) send_sample(a0, a1v);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checks

	// quiet outputs until the first sample
	a_quiet: assert property (@(posedge clk1) disable iff (i_rst)
		!sample_seen |-> (!o_dac_strobe && o_dac0 == '0 && o_dac1 == '0))
	else begin
		time_errs++;
		$display("DAC outputs moved before any sample was sent");
	end

	// exactly one DAC strobe three cycles after each sample strobe
	a_latency: assert property (@(posedge clk1) disable iff (i_rst)
		i_adc_valid |-> ##3 o_dac_strobe)
	else begin
		time_errs++;
		$display("o_dac_strobe missing three cycles after i_adc_valid");
	end

	a_no_extra: assert property (@(posedge clk1) disable iff (i_rst)
		o_dac_strobe |-> $past(i_adc_valid, 3))
	else begin
		time_errs++;
		$display("o_dac_strobe without i_adc_valid three cycles before");
	end

	always @(posedge clk1) begin : check_dac
		logic [31:0] exp_pair;
		if (!i_rst && o_dac_strobe) begin
			if (exp_q.size() == 0) begin
				other_errs++;
				$display("DAC strobe arrived with no sample pending");
			end else begin
				exp_pair = exp_q.pop_front();
				assert (o_dac0 === exp_pair[31:16]) else begin
					val_errs++;
					$display("ERR o_dac0 exp %h got %h", exp_pair[31:16], o_dac0);
				end
				assert (o_dac1 === exp_pair[15:0]) else begin
					val_errs++;
					$display("ERR o_dac1 exp %h got %h", exp_pair[15:0], o_dac1);
				end
			end
		end
	end

	// run limit
	always @(posedge clk1) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence

	initial begin
		i_rst = 1'b1;
		i_adc_valid = 1'b0;
		i_adc0 = '0;
		i_adc1 = '0;
		i_cfg_we = 1'b0;
		i_cfg_op = servo_cfg_pkg::op_set_on;
		i_cfg_ch = 1'b0;
		i_cfg_data = '0;
		for (int ch = 0; ch < 2; ch++) begin
			on_m[ch] = 1'b0;
			a1_m[ch] = 0;
			b0_m[ch] = 0;
			b1_m[ch] = 0;
			xp[ch] = 0;
			yp[ch] = 0;
		end
		repeat (5) @(negedge clk1);
		i_rst = 1'b0;
		// nothing moves after reset
		idle(8);
		// bypass with gaps and then back-to-back strobes
		send_random(N_BYP, 1'b1);
		send_random(N_B2B, 1'b0);
		idle(8);
		// channel 0 low-pass with a step and then random samples
		write_cfg(servo_cfg_pkg::op_set_b0, 1'b0, 18'h08000);
		write_cfg(servo_cfg_pkg::op_set_b1, 1'b0, 18'h04000);
		write_cfg(servo_cfg_pkg::op_set_a1, 1'b0, 18'h08000);
		write_cfg(servo_cfg_pkg::op_set_on, 1'b0, 18'h00001);
		send_const(N_STEP, 16'sh4000, 16'sh1000);
		send_random(N_FILT, 1'b1);
		idle(8);
		// near-2 gains push to both limits
		write_cfg(servo_cfg_pkg::op_set_b0, 1'b0, 18'h1FFFF);
		write_cfg(servo_cfg_pkg::op_set_a1, 1'b0, 18'h1FFFF);
		write_cfg(servo_cfg_pkg::op_set_b1, 1'b0, 18'h00000);
		send_const(N_SAT, 16'sh7FFF, 16'sh7FFF);
		send_const(N_SAT, -16'sh8000, -16'sh8000);
		idle(8);
		// channel 1 writes must not disturb channel 0
		write_cfg(servo_cfg_pkg::op_set_b0, 1'b0, 18'h08000);
		write_cfg(servo_cfg_pkg::op_set_a1, 1'b0, 18'h04000);
		send_random(N_ISO, 1'b1);
		write_cfg(servo_cfg_pkg::op_set_a1, 1'b1, 18'h0C000);
		write_cfg(servo_cfg_pkg::op_set_b0, 1'b1, 18'h02000);
		write_cfg(servo_cfg_pkg::op_set_on, 1'b1, 18'h00001);
		send_random(N_ISO, 1'b1);
		// channel 0 off returns to bypass
		write_cfg(servo_cfg_pkg::op_set_on, 1'b0, 18'h00000);
		send_random(N_ISO, 1'b1);
		idle(8);
		assert (exp_q.size() == 0) else begin
			other_errs++;
			$display("%0d expected DAC words never arrived", exp_q.size());
		end
		assert (sat_pos_hit && sat_neg_hit) else begin
			other_errs++;
			$display("saturation test did not reach both signed limits");
		end
		$display("errors: value %0d, timing %0d, other %0d", val_errs, time_errs, other_errs);
		if (val_errs + time_errs + other_errs == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
servo_sig_pkg.sv
servo_cfg_pkg.sv
adc_capture.sv
filter_cfg_regs.sv
iir_first_order.sv
dac_output.sv
servo_top.sv
tb_servo.sv
